//--- all.f
hdl/pcs_pkg.sv
hdl/block_intake.sv
hdl/tx_scrambler.sv
hdl/gearbox_seq_counter.sv
hdl/tx_gearbox.sv
hdl/pcs_tx_top.sv
verification/pcs_tx_assert.sv
verification/pcs_tx_tb.sv

//--- hdl/block_intake.sv
`timescale 1ns/10ps

module block_intake import pcs_pkg::*; (
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_req,
    input  header_t  i_header,
    input  payload_t i_payload,
    input  logic     i_frame_word,   // High half being loaded
    input  logic     i_pause,
    output logic     o_ack,
    output word_t    o_half_word,
    output header_t  o_header
);

    intake_state_t state;

    header_t  cur_header;    // Block being sent
    payload_t cur_payload;
    header_t  hold_header;   // One-deep holding register
    payload_t hold_payload;
    logic     hold_valid;

    logic retire;            // Current block done after this cycle
    logic free;
    logic accept;

    assign retire = i_frame_word && !i_pause;          // End of odd, non-pause value
    assign free   = !hold_valid || retire;             // Slot empties this cycle
    assign accept = i_req && free && (state != WAIT_REQ_LOW);

    assign o_ack = (state == WAIT_REQ_LOW);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (i_req) begin
                        state <= accept ? WAIT_REQ_LOW : HOLD;   // Back-pressure goes to HOLD
                    end
                end
                HOLD: begin
                    if (accept) begin
                        state <= WAIT_REQ_LOW;
                    end
                end
                WAIT_REQ_LOW: begin
                    if (!i_req) begin
                        state <= IDLE;   // Ack drops once req seen low
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Holding register valid flag, a new block wins over retirement
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            hold_valid <= 1'b0;
        end else if (accept) begin
            hold_valid <= 1'b1;
        end else if (retire) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            hold_header  <= i_header;
            hold_payload <= i_payload;
        end
    end

    // Current block, idle inserted when nothing is held
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cur_header  <= SYNC_CTRL;
            cur_payload <= IDLE_PAYLOAD;
        end else if (retire) begin
            cur_header  <= hold_valid ? hold_header  : SYNC_CTRL;
            cur_payload <= hold_valid ? hold_payload : IDLE_PAYLOAD;
        end
    end

    assign o_half_word = i_frame_word ? cur_payload[DATA_WIDTH +: DATA_WIDTH]
                                      : cur_payload[0 +: DATA_WIDTH];
    assign o_header    = cur_header;   // Never scrambled

endmodule

//--- hdl/gearbox_seq_counter.sv
`timescale 1ns/10ps

module gearbox_seq_counter import pcs_pkg::*; (
    input  logic    i_clk,
    input  logic    i_reset,
    output gb_seq_t o_seq,     // 0 to SEQ_LAST
    output logic    o_pause    // No load this cycle
);

    gb_seq_t count;

    // 33 values per 16 blocks, so 1056 bits fit 33 words
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            count <= '0;
        end else if (count == gb_seq_t'(SEQ_LAST)) begin
            count <= '0;   // Wrap after the pause cycle
        end else begin
            count <= count + 1'b1;
        end
    end

    assign o_seq   = count;
    assign o_pause = (count == gb_seq_t'(SEQ_LAST));

endmodule

//--- hdl/pcs_pkg.sv
package pcs_pkg;

    // Widths fixed by 64b/66b and the 32-bit transceiver interface
    localparam int DATA_WIDTH     = 32;    // Output word, one block half
    localparam int HEADER_WIDTH   = 2;     // Sync header
    localparam int SEQUENCE_WIDTH = 6;     // Gearbox sequence value
    localparam int SEQ_LAST       = 32;    // Loading pauses on this value

    typedef logic [DATA_WIDTH-1:0]     word_t;     // Half block or output word
    typedef logic [HEADER_WIDTH-1:0]   header_t;   // Sync header
    typedef logic [2*DATA_WIDTH-1:0]   payload_t;  // Block payload
    typedef logic [SEQUENCE_WIDTH-1:0] gb_seq_t;   // Gearbox sequence

    // Sync header codes, bit 0 goes on the line first
    localparam header_t SYNC_DATA = 2'b01;
    localparam header_t SYNC_CTRL = 2'b10;

    // Idle control block: type 1E, eight zero control codes
    localparam payload_t IDLE_PAYLOAD = 64'h0000_0000_0000_001E;

    // x^58 + x^39 + 1, as taps into the history of scrambled bits
    localparam int SCR_TAP_A = 38;
    localparam int SCR_TAP_B = 57;

    // Four-phase intake handshake
    typedef enum logic [1:0] {
        IDLE,           // Ack low, waiting for req
        HOLD,           // Req seen, holding register still full
        WAIT_REQ_LOW    // Ack high until req drops
    } intake_state_t;

endpackage

//--- hdl/pcs_tx_top.sv
`timescale 1ns/10ps

module pcs_tx_top import pcs_pkg::*; (
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_req,       // Four-phase block request
    input  header_t  i_header,
    input  payload_t i_payload,
    output logic     o_ack,
    output word_t    o_tx_data    // To the transceiver, bit 0 first
);

    gb_seq_t seq;
    logic    pause;
    logic    frame_word;   // High half on this cycle
    word_t   half_word;    // Raw payload half
    word_t   scr_word;
    header_t blk_header;

    block_intake intake_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_req        (i_req),
        .i_header     (i_header),
        .i_payload    (i_payload),
        .i_frame_word (frame_word),
        .i_pause      (pause),
        .o_ack        (o_ack),
        .o_half_word  (half_word),
        .o_header     (blk_header)
    );

    tx_scrambler scrambler_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_word  (half_word),
        .i_pause (pause),
        .o_word  (scr_word)
    );

    gearbox_seq_counter seq_counter_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .o_seq   (seq),
        .o_pause (pause)
    );

    tx_gearbox gearbox_i (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_data        (scr_word),
        .i_header      (blk_header),
        .i_gearbox_seq (seq),
        .i_pause       (pause),
        .o_data        (o_tx_data),
        .o_frame_word  (frame_word)
    );

endmodule

//--- hdl/tx_gearbox.sv
`timescale 1ns/10ps

module tx_gearbox import pcs_pkg::*; (
    input  logic    i_clk,
    input  logic    i_reset,
    input  word_t   i_data,          // Scrambled half
    input  header_t i_header,
    input  gb_seq_t i_gearbox_seq,
    input  logic    i_pause,
    output word_t   o_data,
    output logic    o_frame_word
);

    // Output buffer, low word leaves every cycle
    logic [2*DATA_WIDTH+HEADER_WIDTH-1:0] obuf;
    logic [2*DATA_WIDTH+HEADER_WIDTH-1:0] next_obuf;

    logic    load_header;
    gb_seq_t header_idx;
    gb_seq_t data_idx;

    assign load_header  = !i_gearbox_seq[0];   // Even values carry the header
    assign o_frame_word =  i_gearbox_seq[0];   // Odd values take the high half

    // Residue of earlier blocks fills bits below the sequence value
    assign header_idx = i_gearbox_seq;
    assign data_idx   = load_header ? i_gearbox_seq + gb_seq_t'(HEADER_WIDTH)
                                    : i_gearbox_seq + 1'b1;

    // Each bit comes from one of three places
    //   new header or data word, loaded over everything else
    //   upper word shifted down into the low word
    //   its own old value, for bits not yet reached
    always_comb begin
        next_obuf = obuf;
        next_obuf[0 +: DATA_WIDTH] = obuf[DATA_WIDTH +: DATA_WIDTH];   // Shift down

        if (!i_pause) begin   // Pause keeps shifting, loads nothing
            for (int gi = 0; gi < 2*DATA_WIDTH+HEADER_WIDTH; gi++) begin
                if (load_header && gi >= header_idx && gi < header_idx + HEADER_WIDTH) begin
                    next_obuf[gi] = i_header[gi - header_idx];
                end
                if (gi >= data_idx && gi < data_idx + DATA_WIDTH) begin
                    next_obuf[gi] = i_data[gi - data_idx];   // D0 or D32 onward
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            obuf <= '0;
        end else begin
            obuf <= next_obuf;
        end
    end

    // Low word of the next buffer, no gap cycles on the line
    assign o_data = next_obuf[0 +: DATA_WIDTH];

endmodule

//--- hdl/tx_scrambler.sv
`timescale 1ns/10ps

module tx_scrambler import pcs_pkg::*; (
    input  logic  i_clk,
    input  logic  i_reset,
    input  word_t i_word,    // Raw payload half
    input  logic  i_pause,
    output word_t o_word     // Scrambled half, same cycle
);

    // Last 58 scrambled bits, bit 0 is the newest
    logic [SCR_TAP_B:0] scr_state;
    logic [SCR_TAP_B:0] scr_next;
    logic [SCR_TAP_B:0] hist;       // Running history inside the loop
    logic               scr_bit;

    // Serial form unrolled over 32 bits, bit 0 first on the line
    always_comb begin
        hist = scr_state;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            // 39 and 58 bits back in the scrambled stream
            scr_bit   = i_word[i] ^ hist[SCR_TAP_A] ^ hist[SCR_TAP_B];
            o_word[i] = scr_bit;
            hist      = {hist[SCR_TAP_B-1:0], scr_bit};
        end
        scr_next = hist;
    end

    // Frozen on pause so payload bits stay in step with the gearbox
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            scr_state <= '0;
        end else if (!i_pause) begin
            scr_state <= scr_next;
        end
    end

endmodule

//--- verification/pcs_tx_assert.sv
`timescale 1ns/10ps

module pcs_tx_assert import pcs_pkg::*; (
    input logic    i_clk,
    input logic    i_reset,
    input logic    i_req,
    input logic    i_ack,
    input gb_seq_t i_seq,
    input logic    i_pause,
    input header_t i_header    // Header of the block being loaded
);

    // Ack only answers a request that was present
    ack_rise_with_req: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_ack) |-> $past(i_req))
        else $error("ack rose without a pending request");

    // Ack held until the user has dropped req
    ack_fall_after_req_low: assert property (@(posedge i_clk) disable iff (i_reset)
        $fell(i_ack) |-> !$past(i_req))
        else $error("ack fell while request was still high");

    // 33-value gearbox sequence, pause only on the last value
    seq_in_range: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_seq <= gb_seq_t'(32)) && (i_pause == (i_seq == gb_seq_t'(32))))
        else $error("gearbox sequence or pause out of step");

    // Only data or control sync headers reach the gearbox
    header_legal: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_header == 2'b01) || (i_header == 2'b10))
        else $error("illegal sync header loaded");

endmodule

bind pcs_tx_top pcs_tx_assert assert_i (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_req    (i_req),
    .i_ack    (o_ack),
    .i_seq    (seq),
    .i_pause  (pause),
    .i_header (blk_header)
);

//--- verification/pcs_tx_tb.sv
`timescale 1ns/10ps

module pcs_tx_tb import pcs_pkg::*; ();

    localparam int       NUM_FIXED    = 6;     // Hand-written rows
    localparam int       NUM_RANDOM   = 44;    // Back-to-back random rows
    localparam int       NUM_ROWS     = NUM_FIXED + NUM_RANDOM;
    localparam int       RESET_CYCLES = 4;
    localparam int       BLOCK_PERIOD = 2;     // Cycles per 66-bit block, pause aside
    localparam int       DRAIN_CYCLES = 40;    // Pipeline flush plus repeat watch
    localparam header_t  HDR_DATA     = 2'b01;
    localparam header_t  HDR_CTRL     = 2'b10;
    localparam payload_t IDLE_BLOCK   = 64'h0000_0000_0000_001E;   // Type 1E, zero codes

    logic     i_clk;
    logic     i_reset;
    logic     i_req;
    header_t  i_header;
    payload_t i_payload;
    logic     o_ack;
    word_t    o_tx_data;

    // Stimulus table
    header_t  tbl_header  [NUM_ROWS];
    payload_t tbl_payload [NUM_ROWS];
    int       tbl_gap     [NUM_ROWS];   // Idle cycles before req
    int       tbl_hold    [NUM_ROWS];   // Cycles req stays high after ack

    logic [31:0] rng_state   = 32'h3396;
    logic        bit_q[$];               // Serial line bits, oldest first
    logic [57:0] descr_hist  = '0;       // Scrambled payload bits, bit 0 newest
    int          exp_idx     = 0;        // Next table row to appear on the line
    int          cycle_count = 0;
    int          cycle_limit = 1000;

    pcs_tx_top dut_i (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_req     (i_req),
        .i_header  (i_header),
        .i_payload (i_payload),
        .o_ack     (o_ack),
        .o_tx_data (o_tx_data)
    );

    always #4 i_clk = ~i_clk;   // 8 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s, got %h, expected %h", $time, msg, actual,
                     expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping on first error");
        end
    endtask

    task automatic set_row(input int r, input header_t hdr, input payload_t pay,
                           input int gap, input int hold);
        tbl_header[r]  = hdr;
        tbl_payload[r] = pay;
        tbl_gap[r]     = gap;
        tbl_hold[r]    = hold;
    endtask

    task automatic build_table();
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        logic [31:0] r_ctl;
        int          gap_total;
        set_row(0, HDR_DATA, 64'h0123_4567_89AB_CDEF, 24, 0);   // Long idle lead-in
        set_row(1, HDR_CTRL, 64'h0000_0000_0000_0078, 3, 1);    // Start control block
        set_row(2, HDR_DATA, 64'hFFFF_FFFF_FFFF_FFFF, 0, 2);
        set_row(3, HDR_DATA, 64'h0000_0000_0000_0000, 5, 0);
        set_row(4, HDR_CTRL, 64'h55AA_55AA_0000_004B, 1, 1);    // Ordered set
        set_row(5, HDR_DATA, 64'hA5A5_5A5A_C3C3_3C3C, 0, 0);
        for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
            draw_random(r_hi);
            draw_random(r_lo);
            draw_random(r_ctl);
            set_row(r, r_ctl[0] ? HDR_DATA : HDR_CTRL, {r_hi, r_lo}, 0, int'(r_ctl[9:8]) % 3);
            if (tbl_header[r] == HDR_CTRL && tbl_payload[r] == IDLE_BLOCK)
                tbl_payload[r][63] = 1'b1;   // Keep it apart from idle
        end
        gap_total = 0;
        for (int r = 0; r < NUM_ROWS; r++)
            gap_total += tbl_gap[r];
        cycle_limit = NUM_ROWS * 3 * BLOCK_PERIOD + gap_total + RESET_CYCLES + DRAIN_CYCLES;
    endtask

    // One four-phase exchange, all driving at 1 ns past the edge
    task automatic send_block(input int r);
        repeat (tbl_gap[r]) begin
            @(posedge i_clk);
            #1;
        end
        i_header  = tbl_header[r];
        i_payload = tbl_payload[r];
        i_req     = 1'b1;
        while (!o_ack) begin
            @(posedge i_clk);
            #1;
        end
        repeat (tbl_hold[r]) begin
            @(posedge i_clk);
            #1;
        end
        i_req     = 1'b0;
        i_header  = ~tbl_header[r];    // Data may change once req is low
        i_payload = ~tbl_payload[r];
        while (o_ack) begin
            @(posedge i_clk);
            #1;
        end
    endtask

    // Cut one 66-bit block off the line and descramble its payload
    task automatic cut_block();
        header_t  hdr;
        payload_t pay;
        logic     s;
        hdr[0] = bit_q.pop_front();   // Header bit 0 leaves first
        hdr[1] = bit_q.pop_front();
        for (int i = 0; i < 64; i++) begin
            s          = bit_q.pop_front();
            pay[i]     = s ^ descr_hist[38] ^ descr_hist[57];   // 39 and 58 bits back
            descr_hist = {descr_hist[56:0], s};
        end
        if (hdr != HDR_CTRL || pay != IDLE_BLOCK) begin   // Idle blocks are dropped
            if (exp_idx >= NUM_ROWS) begin
                $display("extra non-idle block on the line at %0d ns, a block was repeated",
                         $time);
                $display("*** TEST FAILED ***");
                $fatal(1, "stopping on first error");
            end
            check_value(64'(hdr), 64'(tbl_header[exp_idx]),
                        $sformatf("header of row %0d", exp_idx));
            check_value(pay, tbl_payload[exp_idx], $sformatf("payload of row %0d", exp_idx));
            exp_idx++;
        end
    endtask

    // Line monitor, output stable at the falling edge
    always @(negedge i_clk) begin
        if (!i_reset) begin
            for (int i = 0; i < 32; i++)
                bit_q.push_back(o_tx_data[i]);
            while (bit_q.size() >= 66)
                cut_block();
        end
    end

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "run exceeded its cycle limit");
        end
    end

    initial begin
        i_clk     = 1'b0;
        i_reset   = 1'b1;
        i_req     = 1'b0;
        i_header  = HDR_CTRL;
        i_payload = '0;
        build_table();
        repeat (RESET_CYCLES) begin
            @(posedge i_clk);
            #1;
            check_value(64'(o_ack), 64'd0, "ack during reset");
        end
        i_reset = 1'b0;
        @(posedge i_clk);
        #1;
        check_value(64'(o_ack), 64'd0, "ack after reset");
        for (int r = 0; r < NUM_ROWS; r++)
            send_block(r);
        while (exp_idx < NUM_ROWS) begin   // Last blocks still in the pipeline
            @(posedge i_clk);
            #1;
        end
        repeat (8 * BLOCK_PERIOD) @(posedge i_clk);   // Watch for repeated blocks
        #1;
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
